// ==== ooo_pkg.sv ====
/*
  Shared widths, queue codes, queue depth and vector types for the
  dispatch and issue back end.
*/
package ooo_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int DISPATCH_WIDTH = 4;                // micro-ops offered per group.
  localparam int NUM_IQ         = 3;
  localparam int IQ_DEPTH       = 8;                // kept a power of two so pointers wrap.

  localparam int LANE_IDX_W = $clog2(DISPATCH_WIDTH);
  localparam int IQ_PTR_W   = $clog2(IQ_DEPTH);
  localparam int IQ_COUNT_W = $clog2(IQ_DEPTH + 1); // must hold the full depth.

  localparam int ROB_TAG_W  = 6;
  localparam int UOP_OPND_W = 18;                   // operand bits below the tag.

  ////////////////////////////////////////////////////////////////////////////
  // queue codes
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [1:0] iq_code_t;

  localparam iq_code_t IQ_INT = 2'd0;
  localparam iq_code_t IQ_MEM = 2'd1;
  localparam iq_code_t IQ_FP  = 2'd2;               // code 3 has no queue and is dropped.

  // queue q collects the lanes whose code equals entry q.
  localparam iq_code_t [NUM_IQ-1:0] IQ_CODE_OF = {IQ_FP, IQ_MEM, IQ_INT};

  ////////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [ROB_TAG_W-1:0] rob_tag_t;

  // the tag sits in the top bits and the rest is carried opaque.
  typedef logic [$bits(rob_tag_t)+UOP_OPND_W-1:0] uop_word_t;

  typedef logic [LANE_IDX_W-1:0] lane_idx_t;
  typedef logic [IQ_PTR_W-1:0]   iq_ptr_t;
  typedef logic [IQ_COUNT_W-1:0] iq_count_t;

endpackage

// ==== dispatch_selector.sv ====
/*
  Prefix-priority picker for one issue queue. Output slot i names the
  i-th set lane of the ready mask, counting from lane 0.
*/
`timescale 1ns/10ps

module dispatch_selector (
  input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]                     ready,
  output ooo_pkg::lane_idx_t [ooo_pkg::DISPATCH_WIDTH-1:0]       sel,
  output logic [ooo_pkg::DISPATCH_WIDTH-1:0]                     sel_valid
);

  import ooo_pkg::*;

  // lanes still unclaimed when slot i makes its pick.
  logic [DISPATCH_WIDTH-1:0] remain [DISPATCH_WIDTH];

  assign remain[0] = ready;

  // each slot strips the lowest set lane before passing the mask on.
  for (genvar i = 1; i < DISPATCH_WIDTH; i++) begin : g_strip
    assign remain[i] = remain[i-1] & (remain[i-1] - 1'b1);
  end

  always_comb begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      sel[i]       = '0;
      sel_valid[i] = |remain[i];
      // scanning downward leaves the lowest set lane in place.
      for (int j = DISPATCH_WIDTH - 1; j >= 0; j--) begin
        if (remain[i][j]) begin
          sel[i] = lane_idx_t'(j);
        end
      end
    end
  end

endmodule

// ==== dispatch.sv ====
/*
  Dispatch steering. Classifies lanes by queue code, compacts them per queue
  and refuses the whole group when any queue lacks room.
*/
`timescale 1ns/10ps

module dispatch (
  input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]                          in_valid,
  input  ooo_pkg::iq_code_t [ooo_pkg::DISPATCH_WIDTH-1:0]             in_iq,
  input  ooo_pkg::uop_word_t [ooo_pkg::DISPATCH_WIDTH-1:0]            in_uop,
  input  ooo_pkg::iq_count_t [ooo_pkg::NUM_IQ-1:0]                    free_count,
  output logic                                                        dispatch_stall,
  output logic [ooo_pkg::NUM_IQ-1:0][ooo_pkg::DISPATCH_WIDTH-1:0]     wr_valid,
  output ooo_pkg::uop_word_t [ooo_pkg::NUM_IQ-1:0][ooo_pkg::DISPATCH_WIDTH-1:0] wr_uop
);

  import ooo_pkg::*;

  logic [NUM_IQ-1:0][DISPATCH_WIDTH-1:0]      lane_hit;
  lane_idx_t [NUM_IQ-1:0][DISPATCH_WIDTH-1:0] sel;
  logic [NUM_IQ-1:0][DISPATCH_WIDTH-1:0]      sel_valid;
  iq_count_t [NUM_IQ-1:0]                     demand;
  logic [NUM_IQ-1:0]                          short_q;

  ////////////////////////////////////////////////////////////////////////////
  // per-queue classification and compaction
  ////////////////////////////////////////////////////////////////////////////

  for (genvar q = 0; q < NUM_IQ; q++) begin : g_queue
    for (genvar l = 0; l < DISPATCH_WIDTH; l++) begin : g_lane
      assign lane_hit[q][l] = in_valid[l] & (in_iq[l] == IQ_CODE_OF[q]);
    end

    dispatch_selector u_sel (
      .ready     (lane_hit[q]),
      .sel       (sel[q]),
      .sel_valid (sel_valid[q])
    );

    for (genvar s = 0; s < DISPATCH_WIDTH; s++) begin : g_slot
      assign wr_valid[q][s] = sel_valid[q][s] & ~dispatch_stall;
      assign wr_uop[q][s]   = wr_valid[q][s] ? in_uop[sel[q][s]] : '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // group stall
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int q = 0; q < NUM_IQ; q++) begin
      demand[q] = '0;
      for (int s = 0; s < DISPATCH_WIDTH; s++) begin
        demand[q] = demand[q] + iq_count_t'(sel_valid[q][s]);
      end
      short_q[q] = demand[q] > free_count[q];
    end
  end

  assign dispatch_stall = |short_q;   // one short queue holds back every lane.

endmodule

// ==== issue_queue.sv ====
/*
  In-order issue queue. Circular buffer taking up to one dispatch group of
  writes per cycle and retiring one entry at the head.
*/
`timescale 1ns/10ps

module issue_queue (
  input  logic                                              clk,
  input  logic                                              arst_n,
  input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]                wr_valid,
  input  ooo_pkg::uop_word_t [ooo_pkg::DISPATCH_WIDTH-1:0]  wr_uop,
  input  logic                                              pop,
  output logic                                              head_valid,
  output ooo_pkg::uop_word_t                                head_uop,
  output ooo_pkg::iq_count_t                                free_count
);

  import ooo_pkg::*;

  uop_word_t mem [IQ_DEPTH];
  iq_ptr_t   head_ptr;
  iq_ptr_t   tail_ptr;
  iq_count_t wr_count;

  always_comb begin
    wr_count = '0;
    for (int s = 0; s < DISPATCH_WIDTH; s++) begin
      wr_count = wr_count + iq_count_t'(wr_valid[s]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  // slot s lands s places past the tail, wrapping with the pointer width.
  always_ff @(posedge clk) begin
    for (int s = 0; s < DISPATCH_WIDTH; s++) begin
      if (wr_valid[s]) begin
        mem[tail_ptr + iq_ptr_t'(s)] <= wr_uop[s];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head_ptr   <= '0;
      tail_ptr   <= '0;
      free_count <= iq_count_t'(IQ_DEPTH);
    end else begin
      tail_ptr   <= tail_ptr + iq_ptr_t'(wr_count);
      if (pop) begin
        head_ptr <= head_ptr + 1'b1;
      end
      free_count <= free_count - wr_count + iq_count_t'(pop);
    end
  end

  assign head_valid = free_count != iq_count_t'(IQ_DEPTH);
  assign head_uop   = mem[head_ptr];

  ////////////////////////////////////////////////////////////////////////////
  // checks on what dispatch hands over
  ////////////////////////////////////////////////////////////////////////////

  a_no_overflow : assert property (@(posedge clk) disable iff (!arst_n)
    wr_count <= free_count)
    else $error("issue_queue: %0d writes with %0d free", wr_count, free_count);

  a_wr_compact : assert property (@(posedge clk) disable iff (!arst_n)
    (wr_valid & (wr_valid + 1'b1)) == '0)
    else $error("issue_queue: write slots not compacted (%b)", wr_valid);

endmodule

// ==== issue_stage.sv ====
/*
  Issue stage. Pops each queue head whose unit is ready and registers it
  onto that queue's issue port.
*/
`timescale 1ns/10ps

module issue_stage (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  logic [ooo_pkg::NUM_IQ-1:0]                head_valid,
  input  ooo_pkg::uop_word_t [ooo_pkg::NUM_IQ-1:0]  head_uop,
  input  logic [ooo_pkg::NUM_IQ-1:0]                fu_ready,
  output logic [ooo_pkg::NUM_IQ-1:0]                pop,
  output logic [ooo_pkg::NUM_IQ-1:0]                issue_valid,
  output ooo_pkg::uop_word_t [ooo_pkg::NUM_IQ-1:0]  issue_uop
);

  import ooo_pkg::*;

  assign pop = head_valid & fu_ready;   // queues drain independently of each other.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_valid <= '0;
    end else begin
      issue_valid <= pop;
    end
  end

  // the port keeps its last micro-op while no pop happens.
  always_ff @(posedge clk) begin
    for (int q = 0; q < NUM_IQ; q++) begin
      if (pop[q]) begin
        issue_uop[q] <= head_uop[q];
      end
    end
  end

  // a popped head must be an entry that the queue has written.
  for (genvar q = 0; q < NUM_IQ; q++) begin : g_chk
    a_pop_head_known : assert property (@(posedge clk) disable iff (!arst_n)
      pop[q] |-> !$isunknown(head_uop[q]))
      else $error("issue_stage: pop of unwritten head in queue %0d", q);
  end

endmodule

// ==== ooo_backend_top.sv ====
/*
  Dispatch and issue back end. Dispatch feeds three issue queues and the
  issue stage drains them onto one port per functional unit.
*/
`timescale 1ns/10ps

module ooo_backend_top (
  input  logic                                              clk,
  input  logic                                              arst_n,
  input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]                in_valid,
  input  ooo_pkg::iq_code_t [ooo_pkg::DISPATCH_WIDTH-1:0]   in_iq,
  input  ooo_pkg::uop_word_t [ooo_pkg::DISPATCH_WIDTH-1:0]  in_uop,
  input  logic [ooo_pkg::NUM_IQ-1:0]                        fu_ready,
  output logic                                              dispatch_stall,
  output logic [ooo_pkg::NUM_IQ-1:0]                        issue_valid,
  output ooo_pkg::uop_word_t [ooo_pkg::NUM_IQ-1:0]          issue_uop
);

  import ooo_pkg::*;

  logic [NUM_IQ-1:0][DISPATCH_WIDTH-1:0]      wr_valid;
  uop_word_t [NUM_IQ-1:0][DISPATCH_WIDTH-1:0] wr_uop;
  iq_count_t [NUM_IQ-1:0]                     free_count;
  logic [NUM_IQ-1:0]                          head_valid;
  uop_word_t [NUM_IQ-1:0]                     head_uop;
  logic [NUM_IQ-1:0]                          pop;

  dispatch u_dispatch (
    .in_valid       (in_valid),
    .in_iq          (in_iq),
    .in_uop         (in_uop),
    .free_count     (free_count),
    .dispatch_stall (dispatch_stall),
    .wr_valid       (wr_valid),
    .wr_uop         (wr_uop)
  );

  for (genvar q = 0; q < NUM_IQ; q++) begin : g_iq
    issue_queue u_iq (
      .clk        (clk),
      .arst_n     (arst_n),
      .wr_valid   (wr_valid[q]),
      .wr_uop     (wr_uop[q]),
      .pop        (pop[q]),
      .head_valid (head_valid[q]),
      .head_uop   (head_uop[q]),
      .free_count (free_count[q])
    );
  end

  issue_stage u_issue (
    .clk         (clk),
    .arst_n      (arst_n),
    .head_valid  (head_valid),
    .head_uop    (head_uop),
    .fu_ready    (fu_ready),
    .pop         (pop),
    .issue_valid (issue_valid),
    .issue_uop   (issue_uop)
  );

endmodule

// ==== tb_ooo_backend.sv ====
/*
  Testbench for the dispatch and issue back end: clock, reset, stimulus
  table, payload LCG, per-queue reference model, compare tasks and timeout.
*/
`timescale 1ns/10ps

module tb_ooo_backend;

  import ooo_pkg::*;

  localparam int NROWS    = 11;
  localparam int MAX_HOLD = 16;
  localparam int TIMEOUT  = NROWS * (MAX_HOLD + 20) + 200;

  // row = {lane valid[3:0], lane codes lane 3 first[7:0], fu_ready[2:0], hold[4:0], probe}
  localparam logic [20:0] TABLE [NROWS] = '{
    {4'b0001, 8'b00_00_00_00, 3'b111, 5'd4,  1'b1},  // lone INT into empty queues.
    {4'b1111, 8'b10_01_00_00, 3'b111, 5'd0,  1'b0},
    {4'b1111, 8'b01_10_00_01, 3'b111, 5'd0,  1'b0},
    {4'b1011, 8'b00_10_11_01, 3'b111, 5'd0,  1'b0},  // code 3 lane and an invalid lane.
    {4'b1111, 8'b11_11_10_00, 3'b101, 5'd10, 1'b0},
    {4'b1111, 8'b00_00_00_00, 3'b000, 5'd0,  1'b0},  // INT fill, units stopped.
    {4'b1111, 8'b00_00_00_00, 3'b000, 5'd0,  1'b0},
    {4'b0011, 8'b00_00_01_01, 3'b000, 5'd0,  1'b0},  // MEM only, still fits.
    {4'b0111, 8'b00_10_01_00, 3'b000, 5'd3,  1'b0},  // needs INT, so it stalls.
    {4'b0000, 8'b00_00_00_00, 3'b111, 5'd16, 1'b0},  // units restart, pending group goes in.
    {4'b0001, 8'b00_00_00_00, 3'b111, 5'd4,  1'b1}
  };

  logic                                  clk;
  logic                                  arst_n;
  logic [DISPATCH_WIDTH-1:0]             in_valid;
  iq_code_t [DISPATCH_WIDTH-1:0]         in_iq;
  uop_word_t [DISPATCH_WIDTH-1:0]        in_uop;
  logic [NUM_IQ-1:0]                     fu_ready;
  logic                                  dispatch_stall;
  logic [NUM_IQ-1:0]                     issue_valid;
  uop_word_t [NUM_IQ-1:0]                issue_uop;

  uop_word_t   exp_q [NUM_IQ][$];                   // expected micro-ops per queue.
  int          err_value;
  int          err_other;
  int          cycle;
  int          probe_due;
  int          seq;
  int          cur_row;
  logic [31:0] lcg_state;

  ooo_backend_top dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .in_valid       (in_valid),
    .in_iq          (in_iq),
    .in_uop         (in_uop),
    .fu_ready       (fu_ready),
    .dispatch_stall (dispatch_stall),
    .issue_valid    (issue_valid),
    .issue_uop      (issue_uop)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_uop(input string name, input uop_word_t exp, input uop_word_t act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      err_value++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      err_value++;
    end
  endtask

  task automatic drive_group(input logic [3:0] valid, input logic [7:0] codes);
    for (int l = 0; l < DISPATCH_WIDTH; l++) begin
      lcg_state = lcg_next(lcg_state);
      in_uop[l] = {rob_tag_t'(seq), lcg_state[30 -: UOP_OPND_W]};  // tag is the sequence number.
      seq++;
    end
    in_valid = valid;
    in_iq    = codes;
  endtask

  task automatic observe_issues();
    uop_word_t exp;
    for (int q = 0; q < NUM_IQ; q++) begin
      if (issue_valid[q]) begin
        if (exp_q[q].size() == 0) begin
          $display("queue %0d issued a micro-op that was never dispatched to it", q);
          err_other++;
        end else begin
          exp = exp_q[q].pop_front();
          check_uop($sformatf("row %0d issue q%0d", cur_row, q), exp, issue_uop[q]);
        end
      end
    end
    if (cycle == probe_due)
      check_flag($sformatf("row %0d probe latency", cur_row), 1'b1, issue_valid[0]);
  endtask

  // samples at the falling edge, then returns 2 ns after the next rising edge.
  task automatic run_cycle(input bit offering, output bit accepted);
    int   cnt [NUM_IQ];
    logic predict;
    @(negedge clk);
    cycle++;
    observe_issues();
    accepted = 1'b0;
    if (offering) begin
      predict = 1'b0;
      for (int q = 0; q < NUM_IQ; q++) begin
        cnt[q] = 0;
        for (int l = 0; l < DISPATCH_WIDTH; l++) begin
          if (in_valid[l] && int'(in_iq[l]) == q)
            cnt[q]++;
        end
        if (cnt[q] > IQ_DEPTH - exp_q[q].size())
          predict = 1'b1;
      end
      // occupancy is only exact while every unit is stopped.
      if (fu_ready == '0)
        check_flag($sformatf("row %0d stall", cur_row), predict, dispatch_stall);
      if (!dispatch_stall) begin
        accepted = 1'b1;
        for (int l = 0; l < DISPATCH_WIDTH; l++) begin
          if (in_valid[l] && in_iq[l] != 2'd3)
            exp_q[in_iq[l]].push_back(in_uop[l]);
        end
      end
    end
    @(posedge clk);
    #2;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and summary
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [20:0] row;
    int          hold;
    int          waited;
    bit          acc;
    bit          pending;
    bit          stuck;
    arst_n    = 1'b0;
    in_valid  = '0;
    in_iq     = '0;
    in_uop    = '0;
    fu_ready  = '0;
    err_value = 0;
    err_other = 0;
    cycle     = 0;
    probe_due = -1;
    seq       = 0;
    cur_row   = 0;
    pending   = 1'b0;
    lcg_state = 32'd5125;
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;
    @(negedge clk);
    check_flag("reset issue_valid", 1'b0, |issue_valid);
    @(posedge clk);
    #2;
    for (int r = 0; r < NROWS; r++) begin
      cur_row  = r;
      row      = TABLE[r];
      fu_ready = row[8:6];
      hold     = int'(row[5:1]);
      if (row[20:17] != '0) begin
        drive_group(row[20:17], row[16:9]);
        pending = 1'b1;
      end
      waited = 0;
      stuck  = 1'b0;
      while (pending && !stuck) begin
        run_cycle(1'b1, acc);
        if (acc) begin
          pending  = 1'b0;
          in_valid = '0;
          if (row[0])
            probe_due = cycle + 2;
        end else begin
          waited++;
          stuck = (fu_ready == '0) && (waited >= hold);  // the group stays on the lanes.
        end
      end
      if (!pending)
        repeat (hold) run_cycle(1'b0, acc);
    end
    repeat (20) run_cycle(1'b0, acc);
    for (int q = 0; q < NUM_IQ; q++) begin
      if (exp_q[q].size() != 0) begin
        $display("queue %0d never issued %0d dispatched micro-ops", q, exp_q[q].size());
        err_other++;
      end
    end
    $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    int n;
    n = 0;
    while (n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    $display("run did not complete within %0d cycles", n);
    $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== tb.f ====
ooo_pkg.sv
dispatch_selector.sv
dispatch.sv
issue_queue.sv
issue_stage.sv
ooo_backend_top.sv
tb_ooo_backend.sv

// ==== Makefile ====
# Verilator build and run of the back-end testbench.

SIM := obj_dir/sim

.PHONY: all lint clean

all: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "No errors" sim.log

$(SIM): tb.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
	  --top-module tb_ooo_backend -o sim

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module tb_ooo_backend

clean:
	rm -rf obj_dir sim.log
